//--- verilog/sya_pkg.sv
//==========================================================
// Shared widths, vector types and controller state encoding
//==========================================================

package sya_pkg;

    //==========================================================
    // Datapath widths
    //==========================================================
    parameter int ACT_W   = 8;
    parameter int WGT_W   = 8;
    parameter int CHN_W   = 8;

    // Room for ACT_W*WGT_W products summed over up to 2**CHN_W channels
    parameter int PSUM_W  = ACT_W + WGT_W + CHN_W;

    parameter int ADDR_W  = 16;
    parameter int SHIFT_W = 5;

    //==========================================================
    // Vector types
    //==========================================================
    // Two's complement values
    typedef logic [ACT_W-1:0]   act_t;
    typedef logic [WGT_W-1:0]   wgt_t;
    typedef logic [PSUM_W-1:0]  psum_t;

    // Unsigned quantities
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [CHN_W-1:0]   chn_t;
    typedef logic [SHIFT_W-1:0] shift_t;

    //==========================================================
    // Controller FSM
    //==========================================================
    typedef enum logic [1:0] {
        IDLE,
        FEED,
        FLUSH,
        DRAIN
    } ctrl_state_t;

endpackage

//--- verilog/sya_ctrl.sv
//==========================================================
// Job controller with config accept, FSM and step counters
//==========================================================
`timescale 1ns/1ps

module sya_ctrl #(
    parameter int NUM_ROW = 4,
    parameter int NUM_COL = 4
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          cfg_vld,
    output logic          cfg_rdy,
    input  sya_pkg::chn_t cfg_chn,
    input  logic          act_dat_vld,
    input  logic          wgt_dat_vld,
    input  logic          drain_done,
    output logic          start,
    output logic          step,
    output logic          flush,
    output logic          drain
);
    import sya_pkg::*;

    // Zeros needed to push the last channel through the skew and the grid
    localparam int FLUSH_LEN = NUM_ROW + NUM_COL - 1;
    localparam int FLUSH_CW  = $clog2(FLUSH_LEN + 1);

    ctrl_state_t         state;
    ctrl_state_t         state_nxt;
    chn_t                chn_q;
    chn_t                feed_cnt;
    logic [FLUSH_CW-1:0] flush_cnt;
    logic                feed_last;
    logic                flush_last;

    //==========================================================
    // Handshake and strobes
    //==========================================================
    assign cfg_rdy    = (state == IDLE);
    assign start      = cfg_vld && cfg_rdy;
    assign flush      = (state == FLUSH);

    // Both operand vectors are consumed in the same cycle
    assign step       = ((state == FEED) && act_dat_vld && wgt_dat_vld) || flush;

    assign feed_last  = (feed_cnt == chn_q - chn_t'(1));
    assign flush_last = (flush_cnt == FLUSH_CW'(FLUSH_LEN - 1));
    assign drain      = flush && flush_last;

    //==========================================================
    // FSM
    //==========================================================
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:  if (start) state_nxt = FEED;
            FEED:  if (step && feed_last) state_nxt = FLUSH;
            FLUSH: if (flush_last) state_nxt = DRAIN;
            DRAIN: if (drain_done) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    //==========================================================
    // Counters
    //==========================================================
    always_ff @(posedge clk) begin
        if (start) begin
            chn_q <= cfg_chn;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            feed_cnt  <= '0;
            flush_cnt <= '0;
        end else begin
            if (start) begin
                feed_cnt <= '0;
            end else if ((state == FEED) && step) begin
                feed_cnt <= feed_cnt + chn_t'(1);
            end

            // Free runs only while flushing
            if (flush) begin
                flush_cnt <= flush_cnt + FLUSH_CW'(1);
            end else begin
                flush_cnt <= '0;
            end
        end
    end

    a_chn_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> (cfg_chn != '0));

endmodule

//--- verilog/operand_fetch.sv
//==========================================================
// Operand read address generator and edge skew delay line
//==========================================================
`timescale 1ns/1ps

module operand_fetch #(
    parameter int LANES  = 4,
    parameter int DATA_W = 8
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  sya_pkg::addr_t               base,
    input  sya_pkg::chn_t                chn,
    output sya_pkg::addr_t               rd_addr,
    output logic                         rd_addr_vld,
    input  logic                         rd_addr_rdy,
    input  logic [LANES-1:0][DATA_W-1:0] rd_dat,
    input  logic                         step,
    input  logic                         flush,
    output logic [LANES-1:0][DATA_W-1:0] skewed
);
    import sya_pkg::*;

    chn_t                         remain;
    logic                         addr_hs;
    logic [LANES-1:0][DATA_W-1:0] lane_in;

    //==========================================================
    // Address issue
    //==========================================================
    assign addr_hs = rd_addr_vld && rd_addr_rdy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr_vld <= 1'b0;
            rd_addr     <= '0;
            remain      <= '0;
        end else if (start) begin
            rd_addr_vld <= (chn != '0);
            rd_addr     <= base;
            remain      <= chn;
        end else if (addr_hs) begin
            // Last address of the job leaves on this transfer
            if (remain == chn_t'(1)) begin
                rd_addr_vld <= 1'b0;
            end
            rd_addr <= rd_addr + addr_t'(1);
            remain  <= remain - chn_t'(1);
        end
    end

    //==========================================================
    // Skew line
    //==========================================================
    // Zeros replace memory data while the array drains
    assign lane_in = flush ? '0 : rd_dat;

    // Lane 0 enters the array without delay
    assign skewed[0] = lane_in[0];

    for (genvar i = 1; i < LANES; i++) begin : g_skew
        logic [i-1:0][DATA_W-1:0] dly;

        always_ff @(posedge clk) begin
            if (start) begin
                dly <= '0;
            end else if (step) begin
                dly[0] <= lane_in[i];
                for (int k = 1; k < i; k++) begin
                    dly[k] <= dly[k-1];
                end
            end
        end

        assign skewed[i] = dly[i-1];
    end

    a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rd_addr_vld && !rd_addr_rdy |=> rd_addr_vld && $stable(rd_addr));

endmodule

//--- verilog/pe_array.sv
//==========================================================
// Output-stationary grid of multiply-accumulate cells
//==========================================================
`timescale 1ns/1ps

module pe_array #(
    parameter int NUM_ROW = 4,
    parameter int NUM_COL = 4
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      start,
    input  logic                                      step,
    input  sya_pkg::act_t [NUM_ROW-1:0]               act_w,
    input  sya_pkg::wgt_t [NUM_COL-1:0]               wgt_n,
    output sya_pkg::psum_t [NUM_ROW-1:0][NUM_COL-1:0] psum
);
    import sya_pkg::*;

    // Registered operands leaving each cell to the east and south
    act_t [NUM_ROW-1:0][NUM_COL-1:0] act_e;
    wgt_t [NUM_ROW-1:0][NUM_COL-1:0] wgt_s;

    for (genvar i = 0; i < NUM_ROW; i++) begin : g_row
        for (genvar j = 0; j < NUM_COL; j++) begin : g_col
            act_t                          a_in;
            wgt_t                          w_in;
            act_t                          a_q;
            wgt_t                          w_q;
            psum_t                         acc;
            logic signed [ACT_W+WGT_W-1:0] prod;

            // Edge cells take the skewed inputs, inner cells a neighbour
            if (j == 0) begin : g_west
                assign a_in = act_w[i];
            end else begin : g_inner_w
                assign a_in = act_e[i][j-1];
            end

            if (i == 0) begin : g_north
                assign w_in = wgt_n[j];
            end else begin : g_inner_n
                assign w_in = wgt_s[i-1][j];
            end

            assign prod = $signed(a_in) * $signed(w_in);

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    a_q <= '0;
                    w_q <= '0;
                    acc <= '0;
                end else if (start) begin
                    a_q <= '0;
                    w_q <= '0;
                    acc <= '0;
                end else if (step) begin
                    a_q <= a_in;
                    w_q <= w_in;
                    acc <= acc + {{CHN_W{prod[ACT_W+WGT_W-1]}}, prod};
                end
            end

            assign act_e[i][j] = a_q;
            assign wgt_s[i][j] = w_q;
            assign psum[i][j]  = acc;
        end
    end

endmodule

//--- verilog/ofm_writer.sv
//==========================================================
// ReLU, quantization and row-by-row result write
//==========================================================
`timescale 1ns/1ps

module ofm_writer #(
    parameter int NUM_ROW = 4,
    parameter int NUM_COL = 4
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      start,
    input  logic                                      drain,
    input  sya_pkg::psum_t [NUM_ROW-1:0][NUM_COL-1:0] psum,
    input  sya_pkg::addr_t                            ofm_base,
    input  sya_pkg::shift_t                           shift,
    input  sya_pkg::act_t                             zp,
    output sya_pkg::act_t [NUM_COL-1:0]               ofm_wr_dat,
    output sya_pkg::addr_t                            ofm_wr_addr,
    output logic                                      ofm_wr_vld,
    input  logic                                      ofm_wr_rdy,
    output logic                                      drain_done
);
    import sya_pkg::*;

    localparam int ROW_W = (NUM_ROW > 1) ? $clog2(NUM_ROW) : 1;

    addr_t                base_q;
    shift_t               shift_q;
    act_t                 zp_q;
    logic [ROW_W-1:0]     row_q;
    logic                 wr_hs;
    logic                 last_row;
    psum_t [NUM_COL-1:0]  row_psum;

    // Job parameters held for the whole tile
    always_ff @(posedge clk) begin
        if (start) begin
            base_q  <= ofm_base;
            shift_q <= shift;
            zp_q    <= zp;
        end
    end

    //==========================================================
    // Row sequencing
    //==========================================================
    assign wr_hs    = ofm_wr_vld && ofm_wr_rdy;
    assign last_row = (row_q == ROW_W'(NUM_ROW - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ofm_wr_vld <= 1'b0;
            row_q      <= '0;
            drain_done <= 1'b0;
        end else begin
            drain_done <= wr_hs && last_row;
            if (drain) begin
                ofm_wr_vld <= 1'b1;
                row_q      <= '0;
            end else if (wr_hs) begin
                if (last_row) begin
                    ofm_wr_vld <= 1'b0;
                end else begin
                    row_q <= row_q + ROW_W'(1);
                end
            end
        end
    end

    assign ofm_wr_addr = base_q + addr_t'(row_q);

    //==========================================================
    // Quantization of the current row
    //==========================================================
    assign row_psum = psum[row_q];

    for (genvar j = 0; j < NUM_COL; j++) begin : g_quant
        psum_t shifted;

        // Bits above the sum read as zero for large shifts
        assign shifted = row_psum[j] >> shift_q;
        assign ofm_wr_dat[j] = row_psum[j][PSUM_W-1] ? '0
                                                     : act_t'(shifted[ACT_W-1:0] + zp_q);
    end

    // Array is stalled during drain, so the row must not move under back-pressure
    a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ofm_wr_vld && !ofm_wr_rdy |=> ofm_wr_vld && $stable(ofm_wr_dat)
                                      && $stable(ofm_wr_addr));

endmodule

//--- verilog/sya_top.sv
//==========================================================
// Systolic matrix engine top level
//==========================================================
`timescale 1ns/1ps

module sya_top #(
    parameter int NUM_ROW = 4,
    parameter int NUM_COL = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,

    // Job configuration
    input  logic                         cfg_vld,
    output logic                         cfg_rdy,
    input  sya_pkg::addr_t               cfg_act_base,
    input  sya_pkg::addr_t               cfg_wgt_base,
    input  sya_pkg::addr_t               cfg_ofm_base,
    input  sya_pkg::chn_t                cfg_chn,
    input  sya_pkg::shift_t              cfg_shift,
    input  sya_pkg::act_t                cfg_zp,

    // Activation memory
    output sya_pkg::addr_t               act_rd_addr,
    output logic                         act_rd_addr_vld,
    input  logic                         act_rd_addr_rdy,
    input  sya_pkg::act_t [NUM_ROW-1:0]  act_rd_dat,
    input  logic                         act_rd_dat_vld,
    output logic                         act_rd_dat_rdy,

    // Weight memory
    output sya_pkg::addr_t               wgt_rd_addr,
    output logic                         wgt_rd_addr_vld,
    input  logic                         wgt_rd_addr_rdy,
    input  sya_pkg::wgt_t [NUM_COL-1:0]  wgt_rd_dat,
    input  logic                         wgt_rd_dat_vld,
    output logic                         wgt_rd_dat_rdy,

    // Result memory
    output sya_pkg::act_t [NUM_COL-1:0]  ofm_wr_dat,
    output sya_pkg::addr_t               ofm_wr_addr,
    output logic                         ofm_wr_vld,
    input  logic                         ofm_wr_rdy
);
    import sya_pkg::*;

    logic                              start;
    logic                              step;
    logic                              flush;
    logic                              drain;
    logic                              drain_done;
    act_t  [NUM_ROW-1:0]               act_skew;
    wgt_t  [NUM_COL-1:0]               wgt_skew;
    psum_t [NUM_ROW-1:0][NUM_COL-1:0]  psum;

    // Both operand streams advance together on step
    assign act_rd_dat_rdy = step;
    assign wgt_rd_dat_rdy = step;

    sya_ctrl #(.NUM_ROW(NUM_ROW), .NUM_COL(NUM_COL)) u_ctrl (
        .clk(clk), .rst_n(rst_n),
        .cfg_vld(cfg_vld), .cfg_rdy(cfg_rdy), .cfg_chn(cfg_chn),
        .act_dat_vld(act_rd_dat_vld), .wgt_dat_vld(wgt_rd_dat_vld),
        .drain_done(drain_done),
        .start(start), .step(step), .flush(flush), .drain(drain)
    );

    operand_fetch #(.LANES(NUM_ROW), .DATA_W(ACT_W)) u_act_fetch (
        .clk(clk), .rst_n(rst_n), .start(start),
        .base(cfg_act_base), .chn(cfg_chn),
        .rd_addr(act_rd_addr), .rd_addr_vld(act_rd_addr_vld),
        .rd_addr_rdy(act_rd_addr_rdy), .rd_dat(act_rd_dat),
        .step(step), .flush(flush), .skewed(act_skew)
    );

    operand_fetch #(.LANES(NUM_COL), .DATA_W(WGT_W)) u_wgt_fetch (
        .clk(clk), .rst_n(rst_n), .start(start),
        .base(cfg_wgt_base), .chn(cfg_chn),
        .rd_addr(wgt_rd_addr), .rd_addr_vld(wgt_rd_addr_vld),
        .rd_addr_rdy(wgt_rd_addr_rdy), .rd_dat(wgt_rd_dat),
        .step(step), .flush(flush), .skewed(wgt_skew)
    );

    pe_array #(.NUM_ROW(NUM_ROW), .NUM_COL(NUM_COL)) u_pe_array (
        .clk(clk), .rst_n(rst_n), .start(start), .step(step),
        .act_w(act_skew), .wgt_n(wgt_skew), .psum(psum)
    );

    ofm_writer #(.NUM_ROW(NUM_ROW), .NUM_COL(NUM_COL)) u_ofm_writer (
        .clk(clk), .rst_n(rst_n), .start(start), .drain(drain),
        .psum(psum), .ofm_base(cfg_ofm_base), .shift(cfg_shift), .zp(cfg_zp),
        .ofm_wr_dat(ofm_wr_dat), .ofm_wr_addr(ofm_wr_addr),
        .ofm_wr_vld(ofm_wr_vld), .ofm_wr_rdy(ofm_wr_rdy),
        .drain_done(drain_done)
    );

endmodule

//--- sim/tb_clk_gen.sv
//==========================================================
// Testbench clock and power-on reset
//==========================================================
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int HALF_PERIOD = 50,
    parameter int RST_CYCLES  = 3
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Released just after an edge
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

//--- sim/sya_tb.sv
//==========================================================
// Testbench with read memory models, result monitor and
// a reference model of the quantized tile
//==========================================================
`timescale 1ns/1ps

module sya_tb;
    import sya_pkg::*;

    localparam int NUM_ROW = 4;
    localparam int NUM_COL = 4;
    localparam int TMO     = 4000;

    // Operand patterns
    localparam int MODE_RANDOM = 0;
    localparam int MODE_NEG    = 1;
    localparam int MODE_WRAP   = 2;

    logic                  clk;
    logic                  rst_n;
    logic                  cfg_vld;
    logic                  cfg_rdy;
    addr_t                 cfg_act_base, cfg_wgt_base, cfg_ofm_base;
    chn_t                  cfg_chn;
    shift_t                cfg_shift;
    act_t                  cfg_zp;
    addr_t                 act_rd_addr, wgt_rd_addr, ofm_wr_addr;
    logic                  act_rd_addr_vld, wgt_rd_addr_vld;
    logic                  act_rd_addr_rdy = 1'b0;
    logic                  wgt_rd_addr_rdy = 1'b0;
    act_t [NUM_ROW-1:0]    act_rd_dat = '0;
    wgt_t [NUM_COL-1:0]    wgt_rd_dat = '0;
    logic                  act_rd_dat_vld = 1'b0;
    logic                  wgt_rd_dat_vld = 1'b0;
    logic                  act_rd_dat_rdy, wgt_rd_dat_rdy;
    act_t [NUM_COL-1:0]    ofm_wr_dat;
    logic                  ofm_wr_vld;
    logic                  ofm_wr_rdy = 1'b0;

    logic [NUM_ROW*ACT_W-1:0] act_mem [0:65535];
    logic [NUM_COL*WGT_W-1:0] wgt_mem [0:65535];
    logic [NUM_COL*ACT_W-1:0] exp_row [NUM_ROW];
    addr_t                    act_pend[$];
    addr_t                    wgt_pend[$];
    int                       act_cnt = 0;
    int                       wgt_cnt = 0;
    int                       row_cnt = 0;
    bit                       busy = 1'b0;

    // Bases of the running job, kept after the config inputs move on
    addr_t                    job_act_base = '0;
    addr_t                    job_wgt_base = '0;
    addr_t                    job_ofm_base = '0;

    tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

    sya_top #(.NUM_ROW(NUM_ROW), .NUM_COL(NUM_COL)) u_sya_top (.*);

    //==========================================================
    // Checks
    //==========================================================
    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic report_failure(input string what);
        $display("Error: %s", what);
        $display("ERRORS FOUND");
        $fatal(1, "%s", what);
    endtask

    //==========================================================
    // Reference model
    //==========================================================
    function automatic act_t quantize(input int sum, input shift_t sh, input act_t zp);
        int shifted;
        if (sum < 0) begin
            return '0;
        end
        shifted = sum >> sh;
        return act_t'(shifted) + zp;
    endfunction

    function automatic act_t lane_value(input int mode, input bit is_wgt);
        if (mode == MODE_NEG) begin
            return is_wgt ? act_t'(256 - $urandom_range(1, 128)) : act_t'($urandom_range(1, 127));
        end
        if (mode == MODE_WRAP) begin
            return act_t'($urandom_range(0, 127));
        end
        return act_t'($urandom);
    endfunction

    task automatic fill_operands(input int mode);
        for (int k = 0; k < int'(cfg_chn); k++) begin
            for (int i = 0; i < NUM_ROW; i++) begin
                act_mem[addr_t'(cfg_act_base + k)][i*ACT_W +: ACT_W] = lane_value(mode, 1'b0);
            end
            for (int j = 0; j < NUM_COL; j++) begin
                wgt_mem[addr_t'(cfg_wgt_base + k)][j*WGT_W +: WGT_W] = lane_value(mode, 1'b1);
            end
        end
    endtask

    // Output-stationary tile: cell (i, j) sums act lane i times wgt lane j
    task automatic compute_tile();
        int sum;
        for (int i = 0; i < NUM_ROW; i++) begin
            for (int j = 0; j < NUM_COL; j++) begin
                sum = 0;
                for (int k = 0; k < int'(cfg_chn); k++) begin
                    sum += int'($signed(act_mem[addr_t'(cfg_act_base + k)][i*ACT_W +: ACT_W]))
                         * int'($signed(wgt_mem[addr_t'(cfg_wgt_base + k)][j*WGT_W +: WGT_W]));
                end
                exp_row[i][j*ACT_W +: ACT_W] = quantize(sum, cfg_shift, cfg_zp);
            end
        end
    endtask

    //==========================================================
    // Memory models and result monitor
    //==========================================================
    always @(posedge clk) begin : act_model
        logic dat_hs;
        dat_hs = act_rd_dat_vld && act_rd_dat_rdy;
        if (cfg_vld && cfg_rdy) begin
            act_cnt = 0;
        end
        if (dat_hs) begin
            void'(act_pend.pop_front());
        end
        if (act_rd_addr_vld && act_rd_addr_rdy) begin
            check("act_rd_addr", 64'(act_rd_addr), 64'(addr_t'(job_act_base + act_cnt)));
            act_pend.push_back(act_rd_addr);
            act_cnt++;
        end
        #1;
        act_rd_addr_rdy = ($urandom % 4) != 0;
        // Valid stays up until the transfer
        if (!act_rd_dat_vld || dat_hs) begin
            act_rd_dat_vld = (act_pend.size() > 0) && (($urandom % 3) != 0);
            act_rd_dat     = (act_pend.size() > 0) ? act_mem[act_pend[0]] : '0;
        end
    end

    always @(posedge clk) begin : wgt_model
        logic dat_hs;
        dat_hs = wgt_rd_dat_vld && wgt_rd_dat_rdy;
        if (cfg_vld && cfg_rdy) begin
            wgt_cnt = 0;
        end
        if (dat_hs) begin
            void'(wgt_pend.pop_front());
        end
        if (wgt_rd_addr_vld && wgt_rd_addr_rdy) begin
            check("wgt_rd_addr", 64'(wgt_rd_addr), 64'(addr_t'(job_wgt_base + wgt_cnt)));
            wgt_pend.push_back(wgt_rd_addr);
            wgt_cnt++;
        end
        #1;
        wgt_rd_addr_rdy = ($urandom % 4) != 0;
        if (!wgt_rd_dat_vld || dat_hs) begin
            wgt_rd_dat_vld = (wgt_pend.size() > 0) && (($urandom % 3) != 0);
            wgt_rd_dat     = (wgt_pend.size() > 0) ? wgt_mem[wgt_pend[0]] : '0;
        end
    end

    always @(posedge clk) begin : ofm_model
        if (busy) begin
            check("cfg_rdy", 64'(cfg_rdy), 64'(0));
        end
        if (cfg_vld && cfg_rdy) begin
            busy    = 1'b1;
            row_cnt = 0;
        end
        if (ofm_wr_vld && ofm_wr_rdy) begin
            if (!busy) begin
                report_failure("result row written with no job running");
            end
            check("ofm_wr_addr", 64'(ofm_wr_addr), 64'(addr_t'(job_ofm_base + row_cnt)));
            check("ofm_wr_dat", 64'(ofm_wr_dat), 64'(exp_row[row_cnt]));
            row_cnt++;
            if (row_cnt == NUM_ROW) begin
                busy = 1'b0;
            end
        end
        #1;
        ofm_wr_rdy = ($urandom % 2) != 0;
    end

    //==========================================================
    // Job sequencing
    //==========================================================
    task automatic wait_cfg_rdy(input string what);
        int n;
        n = 0;
        @(posedge clk);
        while (cfg_rdy !== 1'b1) begin
            n++;
            if (n > TMO) begin
                report_failure(what);
            end
            @(posedge clk);
        end
    endtask

    task automatic run_job(input int mode, input chn_t chn);
        cfg_act_base = addr_t'($urandom_range(0, 60000));
        cfg_wgt_base = addr_t'($urandom_range(0, 60000));
        cfg_ofm_base = addr_t'($urandom_range(0, 60000));
        cfg_chn      = chn;
        cfg_shift    = (mode == MODE_WRAP) ? shift_t'($urandom_range(8, 31))
                                           : shift_t'($urandom_range(0, 12));
        cfg_zp       = (mode == MODE_WRAP) ? act_t'($urandom_range(128, 255)) : act_t'($urandom);
        fill_operands(mode);
        compute_tile();
        job_act_base = cfg_act_base;
        job_wgt_base = cfg_wgt_base;
        job_ofm_base = cfg_ofm_base;
        cfg_vld = 1'b1;
        wait_cfg_rdy("configuration was not accepted");
        #1;
        cfg_vld = 1'b0;
        // The DUT runs on its own copy of the job from here on
        cfg_act_base = addr_t'($urandom);
        cfg_wgt_base = addr_t'($urandom);
        cfg_ofm_base = addr_t'($urandom);
        cfg_chn      = chn_t'($urandom);
        cfg_shift    = shift_t'($urandom);
        cfg_zp       = act_t'($urandom);
        wait_cfg_rdy("job did not finish and return to idle");
        check("act_rd_addr count", 64'(act_cnt), 64'(chn));
        check("wgt_rd_addr count", 64'(wgt_cnt), 64'(chn));
        check("ofm_wr row count", 64'(row_cnt), 64'(NUM_ROW));
        #1;
    endtask

    initial begin
        int n;
        void'($urandom(32'h5e7d));
        cfg_vld      = 1'b0;
        cfg_act_base = '0;
        cfg_wgt_base = '0;
        cfg_ofm_base = '0;
        cfg_chn      = '0;
        cfg_shift    = '0;
        cfg_zp       = '0;
        for (int a = 0; a < 65536; a++) begin
            for (int i = 0; i < NUM_ROW; i++) begin
                act_mem[a][i*ACT_W +: ACT_W] = lane_value(MODE_RANDOM, 1'b0);
            end
            for (int j = 0; j < NUM_COL; j++) begin
                wgt_mem[a][j*WGT_W +: WGT_W] = lane_value(MODE_RANDOM, 1'b1);
            end
        end

        n = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            n++;
            if (n > 20) begin
                report_failure("reset was never released");
            end
        end
        check("cfg_rdy", 64'(cfg_rdy), 64'(1));
        check("act_rd_addr_vld", 64'(act_rd_addr_vld), 64'(0));
        check("wgt_rd_addr_vld", 64'(wgt_rd_addr_vld), 64'(0));
        check("act_rd_dat_rdy", 64'(act_rd_dat_rdy), 64'(0));
        check("wgt_rd_dat_rdy", 64'(wgt_rd_dat_rdy), 64'(0));
        check("ofm_wr_vld", 64'(ofm_wr_vld), 64'(0));
        #1;

        for (int t = 0; t < 8; t++) begin
            run_job(MODE_RANDOM, chn_t'($urandom_range(1, 40)));
        end
        // Every sum negative, so every lane clamps to zero
        for (int t = 0; t < 3; t++) begin
            run_job(MODE_NEG, chn_t'($urandom_range(1, 40)));
        end
        // Large shifts and zero points that wrap
        for (int t = 0; t < 3; t++) begin
            run_job(MODE_WRAP, chn_t'($urandom_range(1, 40)));
        end
        // Channel count extremes back to back
        run_job(MODE_RANDOM, chn_t'(255));
        run_job(MODE_RANDOM, chn_t'(1));
        run_job(MODE_WRAP, chn_t'(255));
        run_job(MODE_NEG, chn_t'(1));

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- sya.f
verilog/sya_pkg.sv
verilog/sya_ctrl.sv
verilog/operand_fetch.sv
verilog/pe_array.sv
verilog/ofm_writer.sv
verilog/sya_top.sv
sim/tb_clk_gen.sv
sim/sya_tb.sv

//--- Makefile
# Verilator build and run for the systolic matrix engine

VERILATOR ?= verilator
TOP       ?= sya_tb
FILELIST  ?= sya.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only when the pass message shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
